//--- rtl/board_cfg.svh
// Board I/O configuration
// Pin and switch counts, reset hold length and register word map

`ifndef BOARD_CFG_SVH
`define BOARD_CFG_SVH

// Header pins routed through the pin multiplexer
`define BOARD_PIN_NUM 8

// Active-low user switches
`define BOARD_SW_NUM 8

// Cycles the system reset stays high once button and PLL are good
`define BOARD_RST_HOLD 16

// Register word indices seen on the bus
`define BOARD_REG_GPIO_OUT 0
`define BOARD_REG_GPIO_OE  1
`define BOARD_REG_GPIO_IN  2 // Read only
`define BOARD_REG_PIN_SEL  3

`endif

//--- rtl/board_pkg.sv
// Board I/O shared types
// Register bus request and response, pin bundles and pin source codes

`include "board_cfg.svh"

package board_pkg;

  // Host to slave side of the register bus
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  addr;  // Word index
    logic [31:0] wdata;
  } bus_req_t;

  // Slave to host side
  typedef struct packed {
    logic        ack;
    logic [31:0] rdata; // Valid while ack is high
  } bus_rsp_t;

  // Source of each header pin
  typedef enum logic [1:0] {
    PIN_SRC_GPIO     = 2'd0,
    PIN_SRC_UART_TX  = 2'd1,
    PIN_SRC_SPI_SCK  = 2'd2,
    PIN_SRC_SPI_COPI = 2'd3
  } pin_src_e;

  // Peripheral lines offered to the pin multiplexer
  typedef struct packed {
    logic uart_tx;
    logic spi_sck;
    logic spi_copi;
  } periph_out_t;

  // Output value and output enable, one bit per pin
  typedef struct packed {
    logic [`BOARD_PIN_NUM-1:0] out;
    logic [`BOARD_PIN_NUM-1:0] oe;
  } pin_bus_t;

endpackage

//--- rtl/rst_ctrl.sv
// Reset controller
// Holds the system in reset until the PLL locks and the button is released,
// then counts out the hold time and lights the boot-ok LED

`include "board_cfg.svh"

module rst_ctrl (
  input  logic clk_i,
  input  logic reset_i,      // Reset button
  input  logic pll_locked_i,
  output logic sys_rst_o,
  output logic boot_ok_o
);

  localparam int unsigned cnt_w = $clog2(`BOARD_RST_HOLD + 1);
  localparam logic [cnt_w-1:0] hold_cnt = cnt_w'(`BOARD_RST_HOLD);
  localparam logic [cnt_w-1:0] last_cnt = hold_cnt - 1'b1;

  logic [cnt_w-1:0] cnt_q;
  logic             hold_clr;

  // Any cause of reset restarts the hold
  assign hold_clr = reset_i || !pll_locked_i;

  always_ff @(posedge clk_i) begin
    if (hold_clr) begin
      cnt_q     <= '0;
      sys_rst_o <= 1'b1;
      boot_ok_o <= 1'b0;
    end else if (cnt_q < hold_cnt) begin
      cnt_q     <= cnt_q + 1'b1;
      sys_rst_o <= (cnt_q < last_cnt); // Falls as the count completes
      boot_ok_o <= (cnt_q == last_cnt);
    end
  end

endmodule

//--- rtl/reg_bus_slave.sv
// Register bus slave
// Four-phase req/ack responder that turns each transaction into one write
// strobe for GPIO or pin select, and latches the selected read word

`include "board_cfg.svh"

module reg_bus_slave (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  board_pkg::bus_req_t         bus_i,
  output board_pkg::bus_rsp_t         bus_o,
  output logic                        gpio_we_o,
  output logic                        pin_sel_we_o,
  output logic [1:0]                  reg_idx_o,
  output logic [31:0]                 wdata_o,
  input  logic [31:0]                 gpio_rdata_i,
  input  logic [2*`BOARD_PIN_NUM-1:0] pin_sel_rdata_i
);

  typedef enum logic {
    ST_IDLE,
    ST_ACK
  } state_e;

  state_e      state_q;
  logic        start;
  logic        wr;
  logic [31:0] rd_word;
  logic [31:0] rdata_q;

  // New transaction seen while idle
  assign start = (state_q == ST_IDLE) && bus_i.req;
  assign wr    = start && bus_i.we;

  assign reg_idx_o = bus_i.addr[1:0];
  assign wdata_o   = bus_i.wdata;

  // Index decode into strobes and read word
  always_comb begin
    gpio_we_o    = 1'b0;
    pin_sel_we_o = 1'b0;
    rd_word      = '0; // Unmapped reads return zero
    case (bus_i.addr)
      `BOARD_REG_GPIO_OUT,
      `BOARD_REG_GPIO_OE: begin
        gpio_we_o = wr;
        rd_word   = gpio_rdata_i;
      end
      `BOARD_REG_GPIO_IN: rd_word = gpio_rdata_i; // Writes ignored
      `BOARD_REG_PIN_SEL: begin
        pin_sel_we_o = wr;
        rd_word      = {{(32-2*`BOARD_PIN_NUM){1'b0}}, pin_sel_rdata_i};
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (bus_i.req) state_q <= ST_ACK;
        ST_ACK:  if (!bus_i.req) state_q <= ST_IDLE; // Wait for host to drop req
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Read word held for the whole ack phase
  always_ff @(posedge clk_i) begin
    if (start) begin
      rdata_q <= rd_word;
    end
  end

  assign bus_o.ack   = (state_q == ST_ACK);
  assign bus_o.rdata = rdata_q;

endmodule

//--- rtl/gpio_regs.sv
// GPIO registers
// Output and output-enable registers, synchronized pin and switch inputs,
// switches inverted so software reads 1 for on

`include "board_cfg.svh"

module gpio_regs (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     we_i,
  input  logic [1:0]               reg_idx_i,
  input  logic [31:0]              wdata_i,
  input  logic [`BOARD_PIN_NUM-1:0] pin_i,
  input  logic [`BOARD_SW_NUM-1:0]  sw_n_i,
  output board_pkg::pin_bus_t      gpio_o,
  output logic [31:0]              rdata_o
);

  localparam int unsigned in_pad_w = 32 - `BOARD_SW_NUM - `BOARD_PIN_NUM;

  logic [`BOARD_PIN_NUM-1:0] out_q;
  logic [`BOARD_PIN_NUM-1:0] oe_q;

  logic [`BOARD_PIN_NUM-1:0] pin_meta_q;
  logic [`BOARD_PIN_NUM-1:0] pin_sync_q;
  logic [`BOARD_SW_NUM-1:0]  sw_meta_q;
  logic [`BOARD_SW_NUM-1:0]  sw_sync_q;

  logic [31:0] in_word;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_q <= '0;
      oe_q  <= '0; // All pins released
    end else if (we_i) begin
      if (reg_idx_i == `BOARD_REG_GPIO_OUT) begin
        out_q <= wdata_i[`BOARD_PIN_NUM-1:0];
      end
      if (reg_idx_i == `BOARD_REG_GPIO_OE) begin
        oe_q <= wdata_i[`BOARD_PIN_NUM-1:0];
      end
    end
  end

  // Two-flop synchronizer on the inputs
  always_ff @(posedge clk_i) begin
    pin_meta_q <= pin_i;
    pin_sync_q <= pin_meta_q;
    sw_meta_q  <= ~sw_n_i; // Switches pull low when on
    sw_sync_q  <= sw_meta_q;
  end

  assign in_word = {{in_pad_w{1'b0}}, sw_sync_q, pin_sync_q};

  always_comb begin
    case (reg_idx_i)
      `BOARD_REG_GPIO_OUT: rdata_o = {{(32-`BOARD_PIN_NUM){1'b0}}, out_q};
      `BOARD_REG_GPIO_OE:  rdata_o = {{(32-`BOARD_PIN_NUM){1'b0}}, oe_q};
      `BOARD_REG_GPIO_IN:  rdata_o = in_word;
      default:             rdata_o = '0;
    endcase
  end

  assign gpio_o.out = out_q;
  assign gpio_o.oe  = oe_q;

endmodule

//--- rtl/pinmux.sv
// Pin multiplexer
// Per-pin source select register and the pad output and enable muxes
// Each pin takes GPIO, UART TX, SPI clock or SPI COPI

`include "board_cfg.svh"

module pinmux (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        sel_we_i,
  input  logic [2*`BOARD_PIN_NUM-1:0] wdata_i,
  input  board_pkg::pin_bus_t         gpio_i,
  input  board_pkg::periph_out_t      periph_i,
  output board_pkg::pin_bus_t         pad_o,
  output logic [2*`BOARD_PIN_NUM-1:0] sel_o
);

  // Pin n select in bits 2n+1 to 2n
  board_pkg::pin_src_e [`BOARD_PIN_NUM-1:0] sel_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `BOARD_PIN_NUM; i++) begin
        sel_q[i] <= board_pkg::PIN_SRC_GPIO;
      end
    end else if (sel_we_i) begin
      for (int i = 0; i < `BOARD_PIN_NUM; i++) begin
        sel_q[i] <= board_pkg::pin_src_e'(wdata_i[2*i +: 2]);
      end
    end
  end

  assign sel_o = sel_q;

  // Pads follow a select or source change in the same cycle
  always_comb begin
    pad_o = '0;
    for (int i = 0; i < `BOARD_PIN_NUM; i++) begin
      case (sel_q[i])
        board_pkg::PIN_SRC_GPIO: begin
          pad_o.out[i] = gpio_i.out[i];
          pad_o.oe[i]  = gpio_i.oe[i];
        end
        board_pkg::PIN_SRC_UART_TX: begin
          pad_o.out[i] = periph_i.uart_tx;
          pad_o.oe[i]  = 1'b1;
        end
        board_pkg::PIN_SRC_SPI_SCK: begin
          pad_o.out[i] = periph_i.spi_sck;
          pad_o.oe[i]  = 1'b1;
        end
        board_pkg::PIN_SRC_SPI_COPI: begin
          pad_o.out[i] = periph_i.spi_copi;
          pad_o.oe[i]  = 1'b1;
        end
        default: begin
          // Unreachable with a 2-bit code, pin left released
          pad_o.out[i] = 1'b0;
          pad_o.oe[i]  = 1'b0;
        end
      endcase
    end
  end

endmodule

//--- rtl/board_top.sv
// Board I/O top level
// Reset controller, register bus slave, GPIO block and pin multiplexer

`include "board_cfg.svh"

module board_top (
  input  logic                      clk_i,
  input  logic                      reset_i,      // Reset button
  input  logic                      pll_locked_i,
  input  board_pkg::bus_req_t       bus_i,
  output board_pkg::bus_rsp_t       bus_o,
  input  board_pkg::periph_out_t    periph_i,
  input  logic [`BOARD_SW_NUM-1:0]  sw_n_i,
  input  logic [`BOARD_PIN_NUM-1:0] pin_i,
  output board_pkg::pin_bus_t       pad_o,
  output logic                      boot_ok_o     // Boot LED
);

  logic                        sys_rst;
  logic                        gpio_we;
  logic                        pin_sel_we;
  logic [1:0]                  reg_idx;
  logic [31:0]                 wdata;
  logic [31:0]                 gpio_rdata;
  logic [2*`BOARD_PIN_NUM-1:0] pin_sel_rdata;
  board_pkg::pin_bus_t         gpio_pins;

  rst_ctrl u_rst_ctrl (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .pll_locked_i(pll_locked_i),
    .sys_rst_o   (sys_rst),
    .boot_ok_o   (boot_ok_o)
  );

  reg_bus_slave u_reg_bus_slave (
    .clk_i          (clk_i),
    .reset_i        (sys_rst),
    .bus_i          (bus_i),
    .bus_o          (bus_o),
    .gpio_we_o      (gpio_we),
    .pin_sel_we_o   (pin_sel_we),
    .reg_idx_o      (reg_idx),
    .wdata_o        (wdata),
    .gpio_rdata_i   (gpio_rdata),
    .pin_sel_rdata_i(pin_sel_rdata)
  );

  gpio_regs u_gpio_regs (
    .clk_i    (clk_i),
    .reset_i  (sys_rst),
    .we_i     (gpio_we),
    .reg_idx_i(reg_idx),
    .wdata_i  (wdata),
    .pin_i    (pin_i),     // Pad inputs straight to the synchronizer
    .sw_n_i   (sw_n_i),
    .gpio_o   (gpio_pins),
    .rdata_o  (gpio_rdata)
  );

  pinmux u_pinmux (
    .clk_i   (clk_i),
    .reset_i (sys_rst),
    .sel_we_i(pin_sel_we),
    .wdata_i (wdata[2*`BOARD_PIN_NUM-1:0]),
    .gpio_i  (gpio_pins),
    .periph_i(periph_i),
    .pad_o   (pad_o),
    .sel_o   (pin_sel_rdata)
  );

endmodule

//--- verification/tb_clk_gen.sv
// Testbench clock source
// Free-running 100 ns clock starting low

module tb_clk_gen (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int half_period = 50;

  initial begin
    clk_o = 1'b0;
  end

  always #half_period clk_o = ~clk_o;

endmodule

//--- verification/board_top_tb.sv
// Board I/O testbench
// Acts as register bus host, checks reset sequencing, register access,
// GPIO drive and input, and pin multiplexing against reference functions

`include "board_cfg.svh"

module board_top_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int pin_num   = `BOARD_PIN_NUM;
  localparam int ack_wait  = 16; // Cycles allowed for each ack edge
  localparam int boot_wait = `BOARD_RST_HOLD + 8;

  logic                   clk;
  logic                   reset;
  logic                   pll_locked;
  board_pkg::bus_req_t    bus_req;
  board_pkg::bus_rsp_t    bus_rsp;
  board_pkg::periph_out_t periph;
  logic [`BOARD_SW_NUM-1:0] sw_n;
  logic [pin_num-1:0]     pin_in;
  board_pkg::pin_bus_t    pad;
  logic                   boot_ok;

  // Expected contents of the writable registers
  logic [pin_num-1:0]   m_out;
  logic [pin_num-1:0]   m_oe;
  logic [2*pin_num-1:0] m_sel;

  logic bus_busy;     // Host transaction in flight
  logic mux_check_en;
  int   value_errs;
  int   timeout_errs;
  int   other_errs;
  int   mux_checks;

  tb_clk_gen u_clk_gen (.clk_o(clk));

  board_top dut_i (
    .clk_i       (clk),
    .reset_i     (reset),
    .pll_locked_i(pll_locked),
    .bus_i       (bus_req),
    .bus_o       (bus_rsp),
    .periph_i    (periph),
    .sw_n_i      (sw_n),
    .pin_i       (pin_in),
    .pad_o       (pad),
    .boot_ok_o   (boot_ok)
  );

  // Expected pads from select word, GPIO registers and peripheral lines
  function automatic board_pkg::pin_bus_t expect_pads(input logic [2*pin_num-1:0] sel,
      input logic [pin_num-1:0] out, input logic [pin_num-1:0] oe,
      input board_pkg::periph_out_t p);
    board_pkg::pin_bus_t r;
    logic [1:0]          src;
    for (int i = 0; i < pin_num; i++) begin
      src = sel[2*i +: 2];
      r.oe[i] = 1'b1; // Peripherals always drive
      case (src)
        board_pkg::PIN_SRC_GPIO: begin
          r.out[i] = out[i];
          r.oe[i]  = oe[i];
        end
        board_pkg::PIN_SRC_UART_TX: r.out[i] = p.uart_tx;
        board_pkg::PIN_SRC_SPI_SCK: r.out[i] = p.spi_sck;
        default:                    r.out[i] = p.spi_copi;
      endcase
    end
    return r;
  endfunction

  // Switches read back as 1 for on
  function automatic logic [31:0] expect_gpio_in(input logic [`BOARD_SW_NUM-1:0] sw,
      input logic [pin_num-1:0] pins);
    return {16'h0, ~sw, pins};
  endfunction

  function automatic logic [31:0] model_word(input logic [3:0] idx);
    case (idx)
      `BOARD_REG_GPIO_OUT: return {24'h0, m_out};
      `BOARD_REG_GPIO_OE:  return {24'h0, m_oe};
      `BOARD_REG_PIN_SEL:  return {16'h0, m_sel};
      default:             return 32'h0;
    endcase
  endfunction

  task automatic compare_pins(input string name, input board_pkg::pin_bus_t act,
      input board_pkg::pin_bus_t exp);
    if (act !== exp) begin
      $display("[FAIL] %0t ns %s: got out=%h oe=%h, expected out=%h oe=%h",
               $time, name, act.out, act.oe, exp.out, exp.oe);
      value_errs++;
    end
  endtask

  task automatic compare_word(input string name, input logic [31:0] act,
      input logic [31:0] exp);
    if (act !== exp) begin
      $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, act, exp);
      value_errs++;
    end
  endtask

  task automatic compare_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("[FAIL] %0t ns %s: got %b, expected %b", $time, name, act, exp);
      value_errs++;
    end
  endtask

  task automatic wait_for_ack(input logic level);
    int waited;
    waited = 0;
    while (bus_rsp.ack !== level && waited < ack_wait) begin
      @(negedge clk);
      waited++;
    end
    if (bus_rsp.ack !== level) begin
      $display("Timeout at %0t ns: bus ack never went to %b", $time, level);
      timeout_errs++;
    end
  endtask

  // Four-phase write, req held for extra cycles after ack when hold > 0
  task automatic bus_write(input logic [3:0] idx, input logic [31:0] data, input int hold);
    bus_busy = 1'b1;
    @(negedge clk);
    bus_req = '{req: 1'b1, we: 1'b1, addr: idx, wdata: data};
    wait_for_ack(1'b1);
    repeat (hold) begin
      @(negedge clk);
      compare_bit("bus_o.ack", bus_rsp.ack, 1'b1); // Held while req stays up
    end
    bus_req.req = 1'b0;
    wait_for_ack(1'b0);
    bus_busy = 1'b0;
  endtask

  task automatic bus_read(input logic [3:0] idx, output logic [31:0] data, input int hold);
    bus_busy = 1'b1;
    @(negedge clk);
    bus_req = '{req: 1'b1, we: 1'b0, addr: idx, wdata: 32'h0};
    wait_for_ack(1'b1);
    data = bus_rsp.rdata;
    repeat (hold) begin
      @(negedge clk);
      compare_bit("bus_o.ack", bus_rsp.ack, 1'b1);
      compare_word("bus_o.rdata", bus_rsp.rdata, data); // Held while req stays up
    end
    bus_req.req = 1'b0;
    wait_for_ack(1'b0);
    bus_busy = 1'b0;
  endtask

  task automatic reg_write(input logic [3:0] idx, input logic [31:0] data, input int hold);
    bus_write(idx, data, hold);
    case (idx)
      `BOARD_REG_GPIO_OUT: m_out = data[pin_num-1:0];
      `BOARD_REG_GPIO_OE:  m_oe  = data[pin_num-1:0];
      `BOARD_REG_PIN_SEL:  m_sel = data[2*pin_num-1:0];
      default: ; // Input word and unmapped indices ignore writes
    endcase
  endtask

  task automatic reg_check(input logic [3:0] idx, input int hold);
    logic [31:0] rd;
    bus_read(idx, rd, hold);
    compare_word($sformatf("bus_o.rdata[idx %0d]", idx), rd, model_word(idx));
  endtask

  task automatic check_reset_release();
    repeat (10) @(negedge clk);
    reset = 1'b0;
    for (int k = 1; k <= `BOARD_RST_HOLD; k++) begin
      @(negedge clk);
      compare_bit("boot_ok_o", boot_ok, k == `BOARD_RST_HOLD);
      if (boot_ok !== 1'b1) begin
        compare_pins("pad_o", pad, expect_pads(m_sel, m_out, m_oe, periph));
      end
    end
    reg_check(`BOARD_REG_GPIO_OUT, 0);
    reg_check(`BOARD_REG_GPIO_OE, 0);
    reg_check(`BOARD_REG_PIN_SEL, 0);
  endtask

  task automatic check_readback();
    logic [3:0] idx;
    repeat (8) begin
      reg_write(`BOARD_REG_GPIO_OUT, $urandom, 0);
      reg_write(`BOARD_REG_GPIO_OE, $urandom, 0);
      reg_write(`BOARD_REG_PIN_SEL, $urandom, 0);
      idx = 4'($urandom_range(15, 4)); // Unmapped range
      reg_write(idx, $urandom, 0);
      reg_check(`BOARD_REG_GPIO_OUT, 0);
      reg_check(`BOARD_REG_GPIO_OE, 0);
      reg_check(`BOARD_REG_PIN_SEL, 0);
      reg_check(idx, 0);
    end
    reg_check(`BOARD_REG_GPIO_OUT, 0);
    reg_check(`BOARD_REG_GPIO_OE, 0);
    reg_check(`BOARD_REG_PIN_SEL, 0);
  endtask

  task automatic check_gpio_drive();
    board_pkg::pin_bus_t exp;
    reg_write(`BOARD_REG_PIN_SEL, 32'h0, 0);
    repeat (6) begin
      reg_write(`BOARD_REG_GPIO_OUT, $urandom, 0);
      reg_write(`BOARD_REG_GPIO_OE, $urandom, 0);
      @(negedge clk);
      exp.out = m_out;
      exp.oe  = m_oe;
      compare_pins("pad_o", pad, exp);
    end
  endtask

  task automatic check_pinmux();
    mux_check_en = 1'b1;
    repeat (12) begin
      reg_write(`BOARD_REG_PIN_SEL, $urandom, 0);
      if ($urandom_range(1, 0) == 1) begin
        reg_write(`BOARD_REG_GPIO_OUT, $urandom, 0);
      end
      repeat (6) begin
        @(negedge clk);
        periph = 3'($urandom);
      end
    end
    @(negedge clk);
    mux_check_en = 1'b0;
  endtask

  task automatic check_gpio_input();
    logic [31:0] rd;
    repeat (8) begin
      @(negedge clk);
      sw_n   = 8'($urandom);
      pin_in = 8'($urandom);
      repeat (3) @(negedge clk);
      bus_read(`BOARD_REG_GPIO_IN, rd, 0);
      compare_word("bus_o.rdata[gpio_in]", rd, expect_gpio_in(sw_n, pin_in));
    end
  endtask

  task automatic check_reset_reentry();
    int waited;
    reg_write(`BOARD_REG_GPIO_OUT, 32'h5a, 0);
    reg_write(`BOARD_REG_GPIO_OE, 32'hff, 0);
    reg_write(`BOARD_REG_PIN_SEL, $urandom, 0);
    @(negedge clk);
    pll_locked = 1'b0;
    waited = 0;
    while (boot_ok !== 1'b0 && waited < ack_wait) begin
      @(negedge clk);
      waited++;
    end
    if (boot_ok !== 1'b0) begin
      $display("Timeout at %0t ns: boot_ok_o stayed high after PLL lock loss", $time);
      timeout_errs++;
    end
    m_out = '0;
    m_oe  = '0;
    m_sel = '0;
    repeat (4) begin
      @(negedge clk);
      compare_pins("pad_o", pad, expect_pads(m_sel, m_out, m_oe, periph));
    end
    pll_locked = 1'b1;
    waited = 0;
    while (boot_ok !== 1'b1 && waited < boot_wait) begin
      @(negedge clk);
      waited++;
    end
    if (boot_ok !== 1'b1) begin
      $display("Timeout at %0t ns: boot_ok_o did not return after PLL relock", $time);
      timeout_errs++;
    end
    reg_check(`BOARD_REG_GPIO_OUT, 3);
    reg_check(`BOARD_REG_GPIO_OE, 4);
    reg_check(`BOARD_REG_PIN_SEL, 5);
    reg_write(`BOARD_REG_GPIO_OUT, $urandom, 5);
    reg_check(`BOARD_REG_GPIO_OUT, 2);
  endtask

  // Pad comparison a quarter period after each rising edge
  always begin
    @(posedge clk);
    #25;
    if (mux_check_en && !bus_busy) begin
      compare_pins("pad_o", pad, expect_pads(m_sel, m_out, m_oe, periph));
      mux_checks++;
    end
  end

  initial begin
    void'($urandom(32'hbf40));
    reset        = 1'b1;
    pll_locked   = 1'b1;
    bus_req      = '0;
    periph       = '0;
    sw_n         = '1; // All switches off
    pin_in       = '0;
    m_out        = '0;
    m_oe         = '0;
    m_sel        = '0;
    bus_busy     = 1'b0;
    mux_check_en = 1'b0;
    value_errs   = 0;
    timeout_errs = 0;
    other_errs   = 0;
    mux_checks   = 0;

    check_reset_release();
    check_readback();
    check_gpio_drive();
    check_pinmux();
    check_gpio_input();
    check_reset_reentry();

    if (mux_checks == 0) begin
      $display("Pad comparison process never ran a check");
      other_errs++;
    end
    $display("Errors: %0d wrong values, %0d timeouts, %0d other",
             value_errs, timeout_errs, other_errs);
    if (value_errs + timeout_errs + other_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+rtl
rtl/board_pkg.sv
rtl/rst_ctrl.sv
rtl/reg_bus_slave.sv
rtl/gpio_regs.sv
rtl/pinmux.sv
rtl/board_top.sv
verification/tb_clk_gen.sv
verification/board_top_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the board I/O testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module board_top_tb -f list.f \
  > build.log 2>&1 \
  && ./obj_dir/Vboard_top_tb > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "=== FAIL ===" sim.log \
  && { echo "Simulation reported failure"; exit 1; } \
  || { echo "Simulation finished without failure"; exit 0; }
